/* dataMemSys.f */
+incdir+logic
logic/lsuPkg.sv
logic/accessAlign.sv
logic/loadFormat.sv
logic/dataMem.sv
logic/memDebugRegs.sv
logic/dataMemTop.sv
testbench/clockGen.sv
testbench/dataMem_properties.sv
testbench/dataMemTb.sv

/* logic/accessAlign.sv */
`include "dataMem_defs.svh"

module accessAlign
(
	input logic clk,
	input logic rstN,
	input lsuPkg::lsuReq req,
	input logic storeLock,
	output logic [`LaneCount-1:0] byteEn,
	output logic [`WordIdxWidth-1:0] wordIdx,
	output logic [`DataWidth-1:0] laneData,
	output logic rdEn,
	output lsuPkg::memOp pendOp,
	output logic [1:0] pendLane,
	output logic pendValid,
	output logic pendWrite,
	output lsuPkg::faultCause pendCause,
	output logic faultPulse,
	output logic [`AddrWidth-1:0] faultAddr
);

	logic [1:0] lane;
	logic misaligned;
	logic [`LaneCount-1:0] sizeMask;
	lsuPkg::faultCause cause;

	assign lane = req.addr[1:0];
	assign wordIdx = req.addr[`WordIdxMsb:`WordIdxLsb];

	// size decode, store data copied into every lane of its size
	always_comb
	begin
		misaligned = 1'b0;
		sizeMask = '0; // no write for funct3 without a store form
		laneData = req.wdata;
		case (req.op)
			lsuPkg::opLb:
			begin
				sizeMask = 4'b0001;
				laneData = {4{req.wdata[7:0]}};
			end
			lsuPkg::opLh:
			begin
				sizeMask = 4'b0011;
				laneData = {2{req.wdata[15:0]}};
				misaligned = lane[0];
			end
			lsuPkg::opLw:
			begin
				sizeMask = 4'b1111;
				misaligned = |lane;
			end
			lsuPkg::opLhu:
				misaligned = lane[0];
			default:
				sizeMask = '0;
		endcase
	end

	// misalignment wins over the lock
	always_comb
	begin
		if (misaligned)
			cause = lsuPkg::causeMisaligned;
		else if (req.write && storeLock)
			cause = lsuPkg::causeLocked;
		else
			cause = lsuPkg::causeNone;
	end

	assign byteEn = (req.valid && req.write && cause == lsuPkg::causeNone) ?
		sizeMask << lane : '0;
	assign rdEn = req.valid && !req.write && !misaligned; // lock never blocks loads

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			pendValid <= 1'b0;
			pendWrite <= 1'b0;
			pendCause <= lsuPkg::causeNone;
		end
		else
		begin
			pendValid <= req.valid;
			pendWrite <= req.write;
			pendCause <= req.valid ? cause : lsuPkg::causeNone;
		end
	end

	always_ff @(posedge clk)
	begin
		pendOp <= req.op; // formatter needs these one cycle on
		pendLane <= lane;
		if (req.valid)
			faultAddr <= req.addr;
	end

	assign faultPulse = pendValid && (pendCause != lsuPkg::causeNone);

endmodule

/* logic/dataMem.sv */
`include "dataMem_defs.svh"

module dataMem
(
	input logic clk,
	input logic [`LaneCount-1:0] byteEn,
	input logic [`WordIdxWidth-1:0] wordIdx,
	input logic [`DataWidth-1:0] laneData,
	input logic rdEn,
	output logic [`DataWidth-1:0] rdWord,
	input logic [`AddrWidth-1:0] watchAddr,
	output logic [`DataWidth-1:0] watchData
);

	logic [`DataWidth-1:0] ram [`MemWords];

	// per-lane write, registered read on the same port
	always_ff @(posedge clk)
	begin
		for (int lane = 0; lane < `LaneCount; lane++)
		begin
			if (byteEn[lane])
				ram[wordIdx][lane*8 +: 8] <= laneData[lane*8 +: 8];
		end
		if (rdEn)
			rdWord <= ram[wordIdx]; // loads never share a cycle with a store
	end

	// debug port, no clock involved
	assign watchData = ram[watchAddr[`WordIdxMsb:`WordIdxLsb]];

endmodule

/* logic/dataMemTop.sv */
`include "dataMem_defs.svh"

module dataMemTop
(
	input logic clk,
	input logic rstN,
	input lsuPkg::lsuReq req,
	output lsuPkg::lsuResp resp,
	input lsuPkg::apbReq apbIn,
	output lsuPkg::apbResp apbOut
);

	logic [`LaneCount-1:0] byteEn;
	logic [`WordIdxWidth-1:0] wordIdx;
	logic [`DataWidth-1:0] laneData;
	logic rdEn;
	logic [`DataWidth-1:0] rdWord;
	lsuPkg::memOp pendOp;
	logic [1:0] pendLane;
	logic pendValid;
	logic pendWrite;
	lsuPkg::faultCause pendCause;
	logic faultPulse;
	logic [`AddrWidth-1:0] faultAddr;
	logic storeLock;
	logic [`AddrWidth-1:0] watchAddr;
	logic [`DataWidth-1:0] watchData;

	accessAlign aligner
	(
		.clk(clk),
		.rstN(rstN),
		.req(req),
		.storeLock(storeLock),
		.byteEn(byteEn),
		.wordIdx(wordIdx),
		.laneData(laneData),
		.rdEn(rdEn),
		.pendOp(pendOp),
		.pendLane(pendLane),
		.pendValid(pendValid),
		.pendWrite(pendWrite),
		.pendCause(pendCause),
		.faultPulse(faultPulse),
		.faultAddr(faultAddr)
	);

	dataMem ram
	(
		.clk(clk),
		.byteEn(byteEn),
		.wordIdx(wordIdx),
		.laneData(laneData),
		.rdEn(rdEn),
		.rdWord(rdWord),
		.watchAddr(watchAddr),
		.watchData(watchData)
	);

	loadFormat formatter
	(
		.pendValid(pendValid),
		.pendOp(pendOp),
		.pendLane(pendLane),
		.pendCause(pendCause),
		.pendWrite(pendWrite),
		.rdWord(rdWord),
		.resp(resp)
	);

	memDebugRegs debugRegs
	(
		.clk(clk),
		.rstN(rstN),
		.apbIn(apbIn),
		.apbOut(apbOut),
		.watchData(watchData),
		.faultPulse(faultPulse),
		.faultAddrIn(faultAddr),
		.storeLock(storeLock),
		.watchAddr(watchAddr)
	);

endmodule

/* logic/dataMem_defs.svh */
`ifndef DATAMEM_DEFS_SVH
`define DATAMEM_DEFS_SVH

`define AddrWidth 32 // byte address bits
`define DataWidth 32 // one RAM word
`define MemWords 1024 // RAM depth in words

// the word index sits just above the two byte offset bits
`define WordIdxWidth $clog2(`MemWords)
`define WordIdxLsb 2
`define WordIdxMsb (`WordIdxLsb + `WordIdxWidth - 1)

`define LaneCount (`DataWidth / 8) // byte lanes per word

`endif

/* logic/loadFormat.sv */
`include "dataMem_defs.svh"

module loadFormat
(
	input logic pendValid,
	input lsuPkg::memOp pendOp,
	input logic [1:0] pendLane,
	input lsuPkg::faultCause pendCause,
	input logic pendWrite,
	input logic [`DataWidth-1:0] rdWord,
	output lsuPkg::lsuResp resp
);

	logic [7:0] byteSel;
	logic [15:0] halfSel;
	logic [`DataWidth-1:0] loadData;
	logic faulted;

	assign byteSel = rdWord[{pendLane, 3'b000} +: 8];
	assign halfSel = pendLane[1] ? rdWord[31:16] : rdWord[15:0]; // lane 0 or 2 only
	assign faulted = pendCause != lsuPkg::causeNone;

	always_comb
	begin
		case (pendOp)
			lsuPkg::opLb:
				loadData = {{24{byteSel[7]}}, byteSel};
			lsuPkg::opLh:
				loadData = {{16{halfSel[15]}}, halfSel};
			lsuPkg::opLbu:
				loadData = {24'b0, byteSel};
			lsuPkg::opLhu:
				loadData = {16'b0, halfSel};
			default:
				loadData = rdWord; // lw
		endcase
	end

	always_comb
	begin
		resp.valid = pendValid;
		resp.fault = faulted;
		// stores and faulted accesses return zero
		resp.rdata = (pendValid && !pendWrite && !faulted) ? loadData : '0;
	end

endmodule

/* logic/lsuPkg.sv */
`include "dataMem_defs.svh"

package lsuPkg;

	// funct3 of the access, stores reuse the first three codes
	typedef enum logic [2:0] {
		opLb = 3'b000, // also sb
		opLh = 3'b001, // also sh
		opLw = 3'b010, // also sw
		opLbu = 3'b100,
		opLhu = 3'b101
	} memOp;

	typedef enum logic [1:0] {
		causeNone = 2'd0,
		causeMisaligned = 2'd1,
		causeLocked = 2'd2 // store blocked by ctrl bit
	} faultCause;

	typedef struct packed {
		logic valid;
		logic write; // 1 => store
		memOp op;
		logic [`AddrWidth-1:0] addr;
		logic [`DataWidth-1:0] wdata;
	} lsuReq;

	typedef struct packed {
		logic valid;
		logic fault;
		logic [`DataWidth-1:0] rdata;
	} lsuResp;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [`AddrWidth-1:0] paddr;
		logic [`DataWidth-1:0] pwdata;
	} apbReq;

	typedef struct packed {
		logic pready;
		logic [`DataWidth-1:0] prdata;
		logic pslverr;
	} apbResp;

	// register offsets of the debug block
	typedef enum logic [`AddrWidth-1:0] {
		regCtrl = 'h0, // bit 0 is storeLock
		regWatchAddr = 'h4,
		regWatchData = 'h8, // read only
		regFaultCount = 'hC, // any write clears
		regFaultAddr = 'h10 // read only
	} regAddr;

endpackage

/* logic/memDebugRegs.sv */
`include "dataMem_defs.svh"

module memDebugRegs
(
	input logic clk,
	input logic rstN,
	input lsuPkg::apbReq apbIn,
	output lsuPkg::apbResp apbOut,
	input logic [`DataWidth-1:0] watchData,
	input logic faultPulse,
	input logic [`AddrWidth-1:0] faultAddrIn,
	output logic storeLock,
	output logic [`AddrWidth-1:0] watchAddr
);

	logic accessPhase;
	logic wrAccess;
	logic addrHit;
	logic wrAllowed;
	logic clearCount;
	logic [`DataWidth-1:0] rdMux;
	logic [`DataWidth-1:0] faultCount;
	logic [`AddrWidth-1:0] faultAddr;

	assign accessPhase = apbIn.psel && apbIn.penable;
	assign wrAccess = accessPhase && apbIn.pwrite;

	// offset decode
	always_comb
	begin
		addrHit = 1'b1;
		wrAllowed = 1'b1;
		rdMux = '0;
		case (apbIn.paddr)
			lsuPkg::regCtrl:
				rdMux = {{(`DataWidth-1){1'b0}}, storeLock};
			lsuPkg::regWatchAddr:
				rdMux = watchAddr;
			lsuPkg::regWatchData:
			begin
				rdMux = watchData; // live RAM contents
				wrAllowed = 1'b0;
			end
			lsuPkg::regFaultCount:
				rdMux = faultCount; // a write clears it
			lsuPkg::regFaultAddr:
			begin
				rdMux = faultAddr;
				wrAllowed = 1'b0;
			end
			default:
			begin
				addrHit = 1'b0;
				wrAllowed = 1'b0;
			end
		endcase
	end

	// zero wait states
	assign apbOut.pready = 1'b1;
	assign apbOut.prdata = (accessPhase && !apbIn.pwrite) ? rdMux : '0;
	assign apbOut.pslverr = accessPhase && (!addrHit || (apbIn.pwrite && !wrAllowed));

	assign clearCount = wrAccess && (apbIn.paddr == lsuPkg::regFaultCount);

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			storeLock <= 1'b0;
			watchAddr <= '0;
		end
		else if (wrAccess)
		begin
			case (apbIn.paddr)
				lsuPkg::regCtrl:
					storeLock <= apbIn.pwdata[0];
				lsuPkg::regWatchAddr:
					watchAddr <= apbIn.pwdata;
				default:
					storeLock <= storeLock;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rstN)
	begin
		if (!rstN)
		begin
			faultCount <= '0;
			faultAddr <= '0;
		end
		else
		begin
			if (clearCount)
				faultCount <= '0; // clear beats a fault in the same cycle
			else if (faultPulse && faultCount != '1)
				faultCount <= faultCount + 1'b1; // saturate at all ones
			if (faultPulse)
				faultAddr <= faultAddrIn;
		end
	end

endmodule

/* testbench/clockGen.sv */
module clockGen
(
	output logic clk,
	output logic rstN
);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk; // period 100
	end

	initial
	begin
		rstN = 1'b0;
		repeat (4) @(posedge clk);
		rstN <= 1'b1; // released on the fourth edge
	end

endmodule

/* testbench/dataMemTb.sv */
module dataMemTb;

	logic clk;
	logic rstN;
	lsuPkg::lsuReq req;
	lsuPkg::lsuResp resp;
	lsuPkg::apbReq apbIn;
	lsuPkg::apbResp apbOut;
	int errCount = 0;
	int checkCount = 0;
	bit loaded = 1'b0;
	logic [7:0] cmdQ[$];
	logic [31:0] opQ[$];
	logic [31:0] addrQ[$];
	logic [31:0] dataQ[$];
	logic [31:0] flagQ[$];

	clockGen clocks (.clk(clk), .rstN(rstN));

	dataMemTop UUT
	(
		.clk(clk),
		.rstN(rstN),
		.req(req),
		.resp(resp),
		.apbIn(apbIn),
		.apbOut(apbOut)
	);

	bind dataMemTop dataMemProperties props
	(
		.clk(clk),
		.rstN(rstN),
		.req(req),
		.resp(resp),
		.apbIn(apbIn),
		.apbOut(apbOut)
	);

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checkCount++;
		assert (got === exp)
		else
		begin
			$display("Error: %s got %h expected %h", name, got, exp);
			errCount++;
		end
	endtask

	// one request, response read back in the following cycle
	task automatic coreAccess(input logic wr, input logic [2:0] op,
		input logic [31:0] addr, input logic [31:0] data, input logic flag);
		lsuPkg::lsuReq r;
		r.valid = 1'b1;
		r.write = wr;
		r.op = lsuPkg::memOp'(op);
		r.addr = addr;
		r.wdata = wr ? data : '0;
		@(posedge clk);
		req <= r;
		@(posedge clk);
		req <= '0;
		@(negedge clk);
		checkValue("resp.valid", resp.valid, 32'h1);
		checkValue("resp.fault", resp.fault, flag);
		checkValue("resp.rdata", resp.rdata, wr ? 32'h0 : data); // stores return zero
	endtask

	task automatic apbTransfer(input logic wr, input logic [31:0] addr,
		input logic [31:0] data, input logic flag);
		lsuPkg::apbReq a;
		a.psel = 1'b1;
		a.penable = 1'b0;
		a.pwrite = wr;
		a.paddr = addr;
		a.pwdata = wr ? data : '0;
		@(posedge clk);
		apbIn <= a; // setup phase
		a.penable = 1'b1;
		@(posedge clk);
		apbIn <= a;
		@(negedge clk);
		while (!apbOut.pready)
			@(negedge clk);
		checkValue("apbOut.pslverr", apbOut.pslverr, flag);
		if (!wr)
			checkValue("apbOut.prdata", apbOut.prdata, data);
		@(posedge clk);
		apbIn <= '0;
	endtask

	initial
	begin
		string line;
		int fd;
		int code;
		logic [7:0] cmd;
		logic [31:0] op;
		logic [31:0] addr;
		logic [31:0] data;
		logic [31:0] flag;
		req = '0;
		apbIn = '0;
		fd = $fopen("testbench/dataMem_stimulus.txt", "r");
		if (fd == 0)
		begin
			$display("Could not open the stimulus file");
			errCount++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				code = $fgets(line, fd);
				if (code > 0 && line.len() > 1 && line[0] != "#")
				begin
					code = $sscanf(line, "%c %h %h %h %h", cmd, op, addr, data, flag);
					if (code != 5)
					begin
						$display("A stimulus line could not be parsed");
						errCount++;
					end
					else
					begin
						cmdQ.push_back(cmd);
						opQ.push_back(op);
						addrQ.push_back(addr);
						dataQ.push_back(data);
						flagQ.push_back(flag);
					end
				end
			end
			$fclose(fd);
		end
		loaded = 1'b1;
		wait (rstN === 1'b1);
		foreach (cmdQ[i])
		begin
			case (cmdQ[i])
				"S":
					coreAccess(1'b1, opQ[i][2:0], addrQ[i], dataQ[i], flagQ[i][0]);
				"L":
					coreAccess(1'b0, opQ[i][2:0], addrQ[i], dataQ[i], flagQ[i][0]);
				"W":
					apbTransfer(1'b1, addrQ[i], dataQ[i], flagQ[i][0]);
				"R":
					apbTransfer(1'b0, addrQ[i], dataQ[i], flagQ[i][0]);
				default:
				begin
					$display("Unknown command in the stimulus file");
					errCount++;
				end
			endcase
		end
		repeat (2) @(posedge clk);
		$display("Checks: %0d  errors: %0d", checkCount, errCount);
		if (errCount == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

	// each command needs at most three cycles, reset and margin on top
	initial
	begin
		wait (loaded);
		#((cmdQ.size() * 4 + 20) * 100);
		$display("Timeout before the stimulus was finished");
		$display("Errors found");
		$finish;
	end

endmodule

/* testbench/dataMem_properties.sv */
module dataMemProperties
(
	input logic clk,
	input logic rstN,
	input lsuPkg::lsuReq req,
	input lsuPkg::lsuResp resp,
	input lsuPkg::apbReq apbIn,
	input lsuPkg::apbResp apbOut
);

	validFollowsReq: assert property (@(posedge clk) disable iff (!rstN)
		resp.valid == $past(req.valid))
		else $error("resp.valid did not follow req.valid by one cycle");

	noFaultData: assert property (@(posedge clk) disable iff (!rstN)
		!(resp.fault && resp.rdata != '0))
		else $error("fault came with nonzero rdata");

	readyHigh: assert property (@(posedge clk) disable iff (!rstN)
		apbOut.pready)
		else $error("pready went low");

	// slave error only while the access phase is up
	errInAccess: assert property (@(posedge clk) disable iff (!rstN)
		apbOut.pslverr |-> (apbIn.psel && apbIn.penable))
		else $error("pslverr raised outside the access phase");

endmodule

/* testbench/dataMem_stimulus.txt */
# cmd op addr data flag with cmd S store, L load, W apb write or R apb read
# data is write data for S and W or the expected read for L and R and flag is the expected fault or pslverr
S 2 00000100 8badf00d 0
L 2 00000100 8badf00d 0
S 0 00000101 000000a5 0
S 0 00000103 0000007e 0
S 1 00000102 00001234 0
S 0 00000100 000000ff 0
S 0 00000102 00000080 0
L 2 00000100 1280a5ff 0
S 2 00000104 9a7bf081 0
L 0 00000104 ffffff81 0
L 0 00000105 fffffff0 0
L 0 00000106 0000007b 0
L 0 00000107 ffffff9a 0
L 4 00000104 00000081 0
L 4 00000105 000000f0 0
L 4 00000106 0000007b 0
L 4 00000107 0000009a 0
L 1 00000104 fffff081 0
L 1 00000106 ffff9a7b 0
L 5 00000104 0000f081 0
L 5 00000106 00009a7b 0
L 1 00000105 00000000 1
L 2 00000106 00000000 1
L 5 00000107 00000000 1
S 1 00000103 00005555 1
S 2 00000101 11111111 1
L 2 00000100 1280a5ff 0
R 0 0000000c 00000005 0
R 0 00000010 00000101 0
W 0 00000000 00000001 0
S 2 00000100 deadbeef 1
S 0 00000104 00000000 1
L 2 00000100 1280a5ff 0
L 0 00000104 ffffff81 0
R 0 0000000c 00000007 0
W 0 00000000 00000000 0
W 0 0000000c 00000000 0
R 0 0000000c 00000000 0
S 2 00000108 cafe0042 0
L 2 00000108 cafe0042 0
W 0 00000004 00000108 0
R 0 00000004 00000108 0
R 0 00000008 cafe0042 0
S 1 00000108 00001357 0
R 0 00000008 cafe1357 0
R 0 00000014 00000000 1
W 0 00000008 12345678 1
